//--- rtl/filter_consts.svh
`ifndef FILTER_CONSTS_SVH
`define FILTER_CONSTS_SVH

// Lanes per filter, one chunk of the sparse memory
`define MEM_SIZE 16
// Lanes carried by one host word
`define BUS_SIZE 4
`define CHANNEL_NUM 4

// Derived sizes
`define FILTER_NUM (`MEM_SIZE / `CHANNEL_NUM)
`define WORDS_PER_FILTER (`MEM_SIZE / `BUS_SIZE)

// Signed dot-product result width
`define ACC_WIDTH 20

`endif

//--- rtl/filter_pkg.sv
`default_nettype none

`include "filter_consts.svh"

package filter_pkg;

	// Host command opcodes
	typedef enum logic [1:0] {
		OP_NONE = 2'd0,
		OP_LOAD = 2'd1,
		OP_DOT  = 2'd2
	} cmd_op_e;

	// One host word of signed bytes, lane 0 in the low byte
	typedef logic signed [`BUS_SIZE-1:0][7:0] lane_data_t;

	// One sparse-map bit per lane
	typedef logic [`BUS_SIZE-1:0] sparsemap_t;

	// Word within a filter and filter number
	typedef logic [$clog2(`WORDS_PER_FILTER)-1:0] word_idx_t;
	typedef logic [$clog2(`FILTER_NUM)-1:0] filter_idx_t;

	// Accumulated dot product
	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

//--- rtl/filter_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface filter_wr_if;
	import filter_pkg::*;

	logic        wr_valid;
	sparsemap_t  wr_sparsemap;
	lane_data_t  wr_data;
	word_idx_t   wr_word_idx;
	filter_idx_t wr_filter_idx;

	// Command stage side
	modport src (output wr_valid, wr_sparsemap, wr_data, wr_word_idx, wr_filter_idx);

	// Memory side
	modport dst (input wr_valid, wr_sparsemap, wr_data, wr_word_idx, wr_filter_idx);

endinterface

`default_nettype wire

//--- rtl/filter_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface filter_rd_if;
	import filter_pkg::*;

	word_idx_t   rd_word_idx;
	filter_idx_t rd_filter_idx;
	// Returned combinationally by the memory
	sparsemap_t  rd_sparsemap;
	lane_data_t  rd_data;

	modport req (output rd_word_idx, rd_filter_idx, input rd_sparsemap, rd_data);

	modport rsp (input rd_word_idx, rd_filter_idx, output rd_sparsemap, rd_data);

endinterface

`default_nettype wire

//--- rtl/filter_cmd_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "filter_consts.svh"

module filter_cmd_stage (
	input  wire                    clk_i,
	input  wire                    rst_i,
	input  wire                    cmd_valid_i,
	input  filter_pkg::cmd_op_e    cmd_op_i,
	input  filter_pkg::filter_idx_t filter_sel_i,
	input  filter_pkg::sparsemap_t sparsemap_i,
	input  filter_pkg::lane_data_t data_i,
	filter_wr_if.src               wr,
	filter_rd_if.req               rd,
	output logic                   dot_valid_o,
	output logic                   dot_last_o,
	output filter_pkg::lane_data_t ifm_data_o
);
	import filter_pkg::*;

	localparam word_idx_t LAST_WORD = word_idx_t'(`WORDS_PER_FILTER - 1);

	logic      is_load;
	logic      is_dot;
	word_idx_t ld_cnt_r;
	word_idx_t dot_cnt_r;

	assign is_load = cmd_valid_i && (cmd_op_i == OP_LOAD);
	assign is_dot  = cmd_valid_i && (cmd_op_i == OP_DOT);

	//////////////////////////////
	// Word counters, one per command kind
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ld_cnt_r  <= '0;
			dot_cnt_r <= '0;
		end else begin
			if (is_load)
				ld_cnt_r <= (ld_cnt_r == LAST_WORD) ? '0 : ld_cnt_r + 1'b1;
			if (is_dot)
				dot_cnt_r <= (dot_cnt_r == LAST_WORD) ? '0 : dot_cnt_r + 1'b1;
		end
	end

	//////////////////////////////
	// Strobes
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr.wr_valid <= 1'b0;
			dot_valid_o <= 1'b0;
			dot_last_o  <= 1'b0;
		end else begin
			wr.wr_valid <= is_load;
			dot_valid_o <= is_dot;
			dot_last_o  <= is_dot && (dot_cnt_r == LAST_WORD);
		end
	end

	// Payload, held until the next command of the same kind
	always_ff @(posedge clk_i) begin
		if (is_load) begin
			wr.wr_sparsemap  <= sparsemap_i;
			wr.wr_data       <= data_i;
			wr.wr_word_idx   <= ld_cnt_r;
			wr.wr_filter_idx <= filter_sel_i;
		end
		if (is_dot) begin
			rd.rd_word_idx   <= dot_cnt_r;
			rd.rd_filter_idx <= filter_sel_i;
			ifm_data_o       <= data_i;
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_filter.sv
`timescale 1ns/1ps
`default_nettype none

`include "filter_consts.svh"

module mem_filter (
	input  wire      clk_i,
	input  wire      rst_i,
	filter_wr_if.dst wr,
	filter_rd_if.rsp rd
);
	import filter_pkg::*;

	// One sparse-map bit and one weight byte per lane, per filter
	logic [`FILTER_NUM-1:0][`MEM_SIZE-1:0]      map_r;
	logic [`FILTER_NUM-1:0][`MEM_SIZE-1:0][7:0] weight_r;

	//////////////////////////////
	// Write port
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			map_r    <= '0;
			weight_r <= '0;
		end else if (wr.wr_valid) begin
			// Word index picks a BUS_SIZE-lane slice of the chunk
			for (int f = 0; f < `FILTER_NUM; f++) begin
				for (int w = 0; w < `WORDS_PER_FILTER; w++) begin
					if ((wr.wr_filter_idx == f) && (wr.wr_word_idx == w)) begin
						map_r[f][`BUS_SIZE*w +: `BUS_SIZE]    <= wr.wr_sparsemap;
						weight_r[f][`BUS_SIZE*w +: `BUS_SIZE] <= wr.wr_data;
					end
				end
			end
		end
	end

	//////////////////////////////
	// Read port, no register
	always_comb begin
		rd.rd_sparsemap = '0;
		rd.rd_data      = '0;
		for (int w = 0; w < `WORDS_PER_FILTER; w++) begin
			if (rd.rd_word_idx == w) begin
				rd.rd_sparsemap = map_r[rd.rd_filter_idx][`BUS_SIZE*w +: `BUS_SIZE];
				rd.rd_data      = weight_r[rd.rd_filter_idx][`BUS_SIZE*w +: `BUS_SIZE];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sparse_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "filter_consts.svh"

module sparse_mac (
	input  wire                    clk_i,
	input  wire                    rst_i,
	input  wire                    dot_valid_i,
	input  wire                    dot_last_i,
	input  filter_pkg::lane_data_t ifm_data_i,
	filter_rd_if.req               rd,
	output logic                   result_valid_o,
	output filter_pkg::acc_t       result_o
);
	import filter_pkg::*;

	localparam int PROD_W = 16;
	localparam int SUM_W  = PROD_W + $clog2(`BUS_SIZE);

	logic signed [PROD_W-1:0] prod [`BUS_SIZE];
	// Heap-ordered adder tree, leaves at the top indices, root at 0
	logic signed [SUM_W-1:0]  node [2*`BUS_SIZE-1];

	logic signed [SUM_W-1:0]  sum_r;
	logic                     s1_valid_r;
	logic                     s1_last_r;
	acc_t                     acc_r;
	acc_t                     acc_next;

	//////////////////////////////
	// Lane products and tree
	for (genvar i = 0; i < `BUS_SIZE; i++) begin : g_lane
		assign prod[i] = $signed(ifm_data_i[i]) * $signed(rd.rd_data[i]);
		// Masked lanes count as zero whatever the stored byte
		assign node[`BUS_SIZE-1+i] = rd.rd_sparsemap[i] ? SUM_W'(prod[i]) : {SUM_W{1'b0}};
	end

	for (genvar n = 0; n < `BUS_SIZE-1; n++) begin : g_tree
		assign node[n] = node[2*n+1] + node[2*n+2];
	end

	// Stage 1, lane sum
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			s1_valid_r <= 1'b0;
			s1_last_r  <= 1'b0;
		end else begin
			s1_valid_r <= dot_valid_i;
			s1_last_r  <= dot_valid_i && dot_last_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (dot_valid_i)
			sum_r <= node[0];
	end

	//////////////////////////////
	// Stage 2, per-filter accumulator
	assign acc_next = acc_r + acc_t'(sum_r);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acc_r          <= '0;
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= s1_valid_r && s1_last_r;
			if (s1_valid_r)
				acc_r <= s1_last_r ? '0 : acc_next;
		end
	end

	// Total of the finished filter
	always_ff @(posedge clk_i) begin
		if (s1_valid_r && s1_last_r)
			result_o <= acc_next;
	end

endmodule

`default_nettype wire

//--- rtl/filter_dot_top.sv
`timescale 1ns/1ps
`default_nettype none

module filter_dot_top (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     cmd_valid_i,
	input  filter_pkg::cmd_op_e     cmd_op_i,
	input  filter_pkg::filter_idx_t filter_sel_i,
	input  filter_pkg::sparsemap_t  sparsemap_i,
	input  filter_pkg::lane_data_t  data_i,
	output logic                    result_valid_o,
	output filter_pkg::acc_t        result_o
);
	import filter_pkg::*;

	logic       dot_valid;
	logic       dot_last;
	lane_data_t ifm_data;

	filter_wr_if wr_bus ();
	filter_rd_if rd_bus ();

	//////////////////////////////
	// Command stage
	filter_cmd_stage cmd_stage_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_op_i     (cmd_op_i),
		.filter_sel_i (filter_sel_i),
		.sparsemap_i  (sparsemap_i),
		.data_i       (data_i),
		.wr           (wr_bus.src),
		.rd           (rd_bus.req),
		.dot_valid_o  (dot_valid),
		.dot_last_o   (dot_last),
		.ifm_data_o   (ifm_data)
	);

	// Filter storage
	mem_filter mem_filter_i (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.wr    (wr_bus.dst),
		.rd    (rd_bus.rsp)
	);

	// Multiply and accumulate, reads the returned word only
	sparse_mac sparse_mac_i (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.dot_valid_i    (dot_valid),
		.dot_last_i     (dot_last),
		.ifm_data_i     (ifm_data),
		.rd             (rd_bus.req),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

endmodule

`default_nettype wire

//--- tb/tb_filter_dot.sv
`timescale 1ns/1ps
`default_nettype none

`include "filter_consts.svh"

module tb_filter_dot;
	import filter_pkg::*;

	typedef struct packed {
		cmd_op_e            op;
		filter_idx_t        filt;
		sparsemap_t         map;
		lane_data_t         data;
		logic               last;
		logic               wait_res;
		logic signed [31:0] exp;
	} row_t;

	logic        clk_i;
	logic        rst_i;
	logic        cmd_valid_i;
	cmd_op_e     cmd_op_i;
	filter_idx_t filter_sel_i;
	sparsemap_t  sparsemap_i;
	lane_data_t  data_i;
	logic        result_valid_o;
	acc_t        result_o;

	// Command table and test names
	row_t  row_q[$];
	string name_q[$];

	// Results still owed by the DUT
	string exp_name_q[$];
	int    exp_val_q[$];
	int    exp_cyc_q[$];

	// Reference copy of the filter memory
	int m_w [`FILTER_NUM][`MEM_SIZE];
	bit m_map [`FILTER_NUM][`MEM_SIZE];
	int m_ld_cnt;
	int m_dot_cnt;
	int m_acc;

	logic [31:0] rng_state;
	int          cycle_cnt;

	filter_dot_top dut_i (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cmd_valid_i    (cmd_valid_i),
		.cmd_op_i       (cmd_op_i),
		.filter_sel_i   (filter_sel_i),
		.sparsemap_i    (sparsemap_i),
		.data_i         (data_i),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

	always #5 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	//////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check(input string name, input int exp, input int act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %0d actual %0d", name, exp, act);
			$display("TB FAILED");
			$fatal(1, "check failed");
		end
	endtask

	task automatic add_load(input string name, input int f, input sparsemap_t map,
			input lane_data_t data);
		row_t r;
		int   idx;
		r = '0;
		r.op = OP_LOAD;
		r.filt = filter_idx_t'(f);
		r.map = map;
		r.data = data;
		for (int lane = 0; lane < `BUS_SIZE; lane++) begin
			idx = m_ld_cnt * `BUS_SIZE + lane;
			m_w[f][idx] = int'($signed(data[lane]));
			m_map[f][idx] = map[lane];
		end
		m_ld_cnt = (m_ld_cnt + 1) % `WORDS_PER_FILTER;
		row_q.push_back(r);
		name_q.push_back(name);
	endtask

	// Expected sum adds weight times IFM byte over mapped lanes only
	task automatic add_dot(input string name, input int f, input lane_data_t data,
			input bit wait_res);
		row_t r;
		int   idx;
		r = '0;
		r.op = OP_DOT;
		r.filt = filter_idx_t'(f);
		r.data = data;
		for (int lane = 0; lane < `BUS_SIZE; lane++) begin
			idx = m_dot_cnt * `BUS_SIZE + lane;
			if (m_map[f][idx])
				m_acc = m_acc + m_w[f][idx] * int'($signed(data[lane]));
		end
		if (m_dot_cnt == `WORDS_PER_FILTER - 1) begin
			r.last = 1'b1;
			r.wait_res = wait_res;
			r.exp = m_acc;
			m_acc = 0;
		end
		m_dot_cnt = (m_dot_cnt + 1) % `WORDS_PER_FILTER;
		row_q.push_back(r);
		name_q.push_back(name);
	endtask

	task automatic drive_idle();
		cmd_valid_i  = 1'b0;
		cmd_op_i     = OP_NONE;
		filter_sel_i = '0;
		sparsemap_i  = '0;
		data_i       = '0;
	endtask

	task automatic wait_results();
		int t;
		t = 0;
		while (exp_val_q.size() != 0) begin
			@(negedge clk_i);
			t++;
			if (t > 40) begin
				$display("Timeout, result_valid_o never pulsed for a finished dot pass");
				$display("TB FAILED");
				$fatal(1, "timeout");
			end
		end
	endtask

	// Result monitor checks value and pulse cycle
	always @(negedge clk_i) begin
		if (!rst_i && result_valid_o === 1'b1) begin
			if (exp_val_q.size() == 0) begin
				$display("result_valid_o pulsed with no dot pass pending");
				$display("TB FAILED");
				$fatal(1, "unexpected result");
			end else begin
				check(exp_name_q[0], exp_val_q[0], int'($signed(result_o)));
				check({exp_name_q[0], " timing"}, exp_cyc_q[0], cycle_cnt);
				void'(exp_name_q.pop_front());
				void'(exp_val_q.pop_front());
				void'(exp_cyc_q.pop_front());
			end
		end
	end

	//////////////////////////////
	// Table build and run

	task automatic build_table();
		lane_data_t ifm [`WORDS_PER_FILTER];
		int         f;
		ifm[0] = 32'h8080_7f01;
		ifm[1] = 32'h1020_30f0;
		ifm[2] = 32'h7f80_01ff;
		ifm[3] = 32'h1122_3344;
		// Cleared memory gives zero
		for (int w = 0; w < 4; w++)
			add_dot("reset_f0", 0, ifm[w], 1'b1);
		for (int w = 0; w < 4; w++)
			add_dot("reset_f3", 3, ifm[w], 1'b1);
		// Dense filter with extreme signed values
		add_load("load_f1", 1, 4'hf, 32'h8080_7f01);
		add_load("load_f1", 1, 4'hf, 32'hff10_8005);
		add_load("load_f1", 1, 4'hf, 32'h8080_8080);
		add_load("load_f1", 1, 4'hf, 32'h01fe_337f);
		for (int w = 0; w < 4; w++)
			add_dot("dense_f1", 1, 32'h807f_8002 + w, 1'b1);
		for (int w = 0; w < 4; w++)
			add_load("load_f0", 0, 4'hf, 32'h0102_0304 * (w + 1));
		// Sparse map hides nonzero bytes
		add_load("load_f2", 2, 4'b0101, 32'h7f7f_7f7f);
		add_load("load_f2", 2, 4'b0000, 32'h8080_8080);
		add_load("load_f2", 2, 4'b1000, 32'h9c11_2233);
		add_load("load_f2", 2, 4'b1110, 32'h05fb_0380);
		for (int w = 0; w < 4; w++)
			add_dot("sparse_f2", 2, ifm[w], 1'b1);
		// Reloaded filter 1 leaves the others unchanged
		for (int w = 0; w < 4; w++)
			add_load("reload_f1", 1, 4'b1011, 32'hf00d_0a80 ^ (w << 8));
		for (int w = 0; w < 4; w++)
			add_dot("reload_f1", 1, ifm[w], 1'b1);
		for (int w = 0; w < 4; w++)
			add_dot("keep_f2", 2, ifm[w], 1'b1);
		for (int w = 0; w < 4; w++)
			add_dot("keep_f0", 0, ifm[w], 1'b1);
		// Back-to-back passes without gaps
		for (int p = 0; p < 4; p++)
			for (int w = 0; w < 4; w++)
				add_dot($sformatf("b2b_f%0d", p), p, ifm[(w + p) % 4], p == 3);
		// Random loads and dots
		for (int k = 0; k < 4; k++)
			for (int w = 0; w < 4; w++)
				add_load($sformatf("rand_load_%0d", k), k,
					sparsemap_t'(xorshift()), xorshift());
		for (int k = 0; k < 8; k++) begin
			if (k % 3 == 2) begin
				f = xorshift() % `FILTER_NUM;
				for (int w = 0; w < 4; w++)
					add_load($sformatf("rand_reload_%0d", k), f,
						sparsemap_t'(xorshift()), xorshift());
			end
			f = xorshift() % `FILTER_NUM;
			for (int w = 0; w < 4; w++)
				add_dot($sformatf("rand_dot_%0d", k), f, xorshift(), (k % 2) == 1);
		end
	endtask

	initial begin
		row_t r;
		clk_i = 1'b0;
		rst_i = 1'b1;
		cycle_cnt = 0;
		rng_state = 32'd23063;
		m_ld_cnt = 0;
		m_dot_cnt = 0;
		m_acc = 0;
		for (int f = 0; f < `FILTER_NUM; f++)
			for (int l = 0; l < `MEM_SIZE; l++) begin
				m_w[f][l] = 0;
				m_map[f][l] = 1'b0;
			end
		drive_idle();
		build_table();

		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		for (int i = 0; i < row_q.size(); i++) begin
			r = row_q[i];
			@(negedge clk_i);
			cmd_valid_i  = 1'b1;
			cmd_op_i     = r.op;
			filter_sel_i = r.filt;
			sparsemap_i  = r.map;
			data_i       = r.data;
			if (r.last) begin
				// Pulse due two edges after the sampling edge
				exp_name_q.push_back(name_q[i]);
				exp_val_q.push_back(r.exp);
				exp_cyc_q.push_back(cycle_cnt + 3);
			end
			if (r.wait_res) begin
				@(negedge clk_i);
				drive_idle();
				wait_results();
			end
		end
		@(negedge clk_i);
		drive_idle();
		wait_results();
		// Quiet period where the monitor flags any stray pulse
		repeat (5) @(negedge clk_i);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/filter_pkg.sv
rtl/filter_wr_if.sv
rtl/filter_rd_if.sv
rtl/filter_cmd_stage.sv
rtl/mem_filter.sv
rtl/sparse_mac.sv
rtl/filter_dot_top.sv
tb/tb_filter_dot.sv
